// ==== common/mem_logger_pkg.sv ====
package mem_logger_pkg;

    // memory geometry.
    localparam int DATA_W    = 32;
    localparam int MEM_DEPTH = 16;
    localparam int MEM_IDX_W = $clog2(MEM_DEPTH);
    localparam int ADDR_W    = MEM_IDX_W + 1;   // the spare bit reaches one word past the end.
    localparam int BE_W      = DATA_W / 8;

    // serial line.
    localparam int BAUD_W     = 16;
    localparam int HEX_DIGITS = DATA_W / 4;
    localparam int MSG_CHARS  = HEX_DIGITS + 2;  // digits, then CR and LF.

    localparam logic [7:0] CHAR_CR = 8'h0D;
    localparam logic [7:0] CHAR_LF = 8'h0A;

    // words that appear on the log.
    localparam logic [DATA_W-1:0] BANNER_WORD  = 32'h3311_2244;
    localparam logic [DATA_W-1:0] STORE_MARK   = 32'h0000_00AA;
    localparam logic [DATA_W-1:0] LOAD_MARK    = 32'h0000_00BB;
    localparam logic [DATA_W-1:0] ERR_WORD     = 32'hEEEE_EEEE;
    localparam logic [DATA_W-1:0] LANE_PATTERN = 32'hA5A5_A5A5;

    localparam logic [BE_W-1:0] BE_ALL = '1;
    localparam logic [BE_W-1:0] BE_TOP = 4'b1000;

    typedef struct packed {
        logic              wr_en;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              bus_err;
    } mem_rsp_t;

    typedef enum logic [3:0] {
        ST_BANNER,
        ST_STORE,
        ST_LANE,
        ST_STORE_MSG,
        ST_LOAD,
        ST_LOAD_MSG,
        ST_REPORT,
        ST_WAIT_MEM,
        ST_WAIT_LOG
    } seq_state_e;

endpackage

// ==== memory/sp_bram.sv ====
`timescale 1ns/10ps

module sp_bram (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,
    input  mem_logger_pkg::mem_req_t  req,
    output logic                      ready,
    output mem_logger_pkg::mem_rsp_t  rsp
);
    import mem_logger_pkg::*;

    logic [DATA_W-1:0]    mem [MEM_DEPTH];
    logic [DATA_W-1:0]    rdata_q;
    logic                 bus_err_q;
    logic                 accept;
    logic                 in_range;
    logic [MEM_IDX_W-1:0] idx;

    // a request is taken once, on the first cycle it is seen.
    assign accept   = enable && !ready;
    assign in_range = req.addr < ADDR_W'(MEM_DEPTH);
    assign idx      = req.addr[MEM_IDX_W-1:0];

    assign rsp = '{rdata: rdata_q, bus_err: bus_err_q};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ready     <= 1'b0;
            bus_err_q <= 1'b0;
        end
        else
        begin
            ready <= accept;
            if (accept)
            begin
                bus_err_q <= !in_range;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rdata_q <= in_range ? mem[idx] : '0;
            if (req.wr_en && in_range)
            begin
                for (int i = 0; i < BE_W; i++)
                begin
                    if (req.be[i])
                    begin
                        mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    // ready is a single-cycle strobe even if enable is still high when it is seen.
    assert property (@(posedge clk) disable iff (!rst_n) ready |=> !ready);

endmodule

// ==== uart/baud_timer.sv ====
`timescale 1ns/10ps

module baud_timer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              bit_en,
    input  logic [mem_logger_pkg::BAUD_W-1:0] baud_div,
    output logic                              bit_tick
);
    import mem_logger_pkg::*;

    logic [BAUD_W-1:0] count_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            count_q  <= '0;
            bit_tick <= 1'b0;
        end
        else if (!bit_en)
        begin
            // idle keeps the count loaded, so it starts fresh on the rise of bit_en.
            count_q  <= baud_div - 1'b1;
            bit_tick <= 1'b0;
        end
        else if (count_q == '0)
        begin
            count_q  <= baud_div - 1'b1;
            bit_tick <= 1'b1;
        end
        else
        begin
            count_q  <= count_q - 1'b1;
            bit_tick <= 1'b0;
        end
    end

endmodule

// ==== uart/uart_hex_logger.sv ====
`timescale 1ns/10ps

module uart_hex_logger (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              trigger,
    input  logic [mem_logger_pkg::DATA_W-1:0] hex_val,
    input  logic [mem_logger_pkg::BAUD_W-1:0] baud_div,
    output logic                              tx,
    output logic                              busy
);
    import mem_logger_pkg::*;

    logic [DATA_W-1:0] word_q;
    logic [3:0]        char_idx;
    logic [3:0]        bit_idx;    // 0 start, 1 to 8 data, 9 stop.
    logic [7:0]        shift_q;
    logic              bit_en;
    logic              bit_tick;

    // ASCII code of character idx of the message for word.
    function automatic logic [7:0] msg_char(input logic [DATA_W-1:0] word,
                                            input logic [3:0]        idx);
        logic [3:0] nib;
        nib = 4'(word >> (4 * (HEX_DIGITS - 1 - idx)));
        case (idx)
            4'd8:    msg_char = CHAR_CR;
            4'd9:    msg_char = CHAR_LF;
            default: msg_char = (nib < 4'd10) ? 8'h30 + {4'h0, nib}   // '0' to '9'.
                                              : 8'h37 + {4'h0, nib};  // 'A' to 'F'.
        endcase
    endfunction

    // the timer runs from the trigger cycle, so the start bit gets its full length.
    assign bit_en = trigger | busy;

    baud_timer i_baud_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .bit_en   (bit_en),
        .baud_div (baud_div),
        .bit_tick (bit_tick)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tx       <= 1'b1;
            busy     <= 1'b0;
            char_idx <= '0;
            bit_idx  <= '0;
        end
        else if (!busy)
        begin
            if (trigger)
            begin
                busy     <= 1'b1;
                tx       <= 1'b0;
                char_idx <= '0;
                bit_idx  <= '0;
            end
        end
        else if (bit_tick)
        begin
            if (bit_idx < 4'd8)
            begin
                tx      <= shift_q[0];    // data goes out LSB first.
                bit_idx <= bit_idx + 1'b1;
            end
            else if (bit_idx == 4'd8)
            begin
                tx      <= 1'b1;
                bit_idx <= 4'd9;
            end
            else if (char_idx == 4'(MSG_CHARS - 1))
            begin
                busy <= 1'b0;    // stop bit of LF is done.
            end
            else
            begin
                tx       <= 1'b0;
                bit_idx  <= '0;
                char_idx <= char_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && trigger)
        begin
            word_q  <= hex_val;
            shift_q <= msg_char(hex_val, 4'd0);
        end
        else if (busy && bit_tick)
        begin
            if (bit_idx < 4'd8)
            begin
                shift_q <= shift_q >> 1;
            end
            else if (bit_idx == 4'd9)
            begin
                shift_q <= msg_char(word_q, char_idx + 1'b1);
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx);

endmodule

// ==== verilog/mem_test_sequencer.sv ====
`timescale 1ns/10ps

module mem_test_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    output logic                              enable,
    output mem_logger_pkg::mem_req_t          mem_req,
    input  logic                              ready,
    input  mem_logger_pkg::mem_rsp_t          mem_rsp,
    output logic                              trigger,
    output logic [mem_logger_pkg::DATA_W-1:0] hex_val,
    input  logic                              busy
);
    import mem_logger_pkg::*;

    seq_state_e        state;
    seq_state_e        next_q;     // where a wait state returns to.
    logic [DATA_W-1:0] pass_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] rdata_q;
    logic              err_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= ST_BANNER;
            next_q  <= ST_BANNER;
            enable  <= 1'b0;
            trigger <= 1'b0;
            pass_q  <= '0;
            addr_q  <= '0;
        end
        else
        begin
            case (state)
                ST_BANNER:
                begin
                    if (!busy)
                    begin
                        hex_val <= BANNER_WORD;
                        trigger <= 1'b1;
                        next_q  <= ST_STORE;
                        state   <= ST_WAIT_LOG;
                    end
                end
                ST_STORE:
                begin
                    mem_req <= '{wr_en: 1'b1, addr: addr_q, wdata: pass_q, be: BE_ALL};
                    enable  <= 1'b1;
                    next_q  <= ST_LANE;
                    state   <= ST_WAIT_MEM;
                end
                ST_LANE:
                begin
                    mem_req <= '{wr_en: 1'b1, addr: addr_q, wdata: LANE_PATTERN, be: BE_TOP};
                    enable  <= 1'b1;
                    next_q  <= ST_STORE_MSG;
                    state   <= ST_WAIT_MEM;
                end
                ST_STORE_MSG:
                begin
                    if (!busy)
                    begin
                        hex_val <= STORE_MARK;
                        trigger <= 1'b1;
                        next_q  <= ST_LOAD;
                        state   <= ST_WAIT_LOG;
                    end
                end
                ST_LOAD:
                begin
                    mem_req <= '{wr_en: 1'b0, addr: addr_q, wdata: '0, be: BE_ALL};
                    enable  <= 1'b1;
                    next_q  <= ST_LOAD_MSG;
                    state   <= ST_WAIT_MEM;
                end
                ST_LOAD_MSG:
                begin
                    if (!busy)
                    begin
                        hex_val <= LOAD_MARK;
                        trigger <= 1'b1;
                        next_q  <= ST_REPORT;
                        state   <= ST_WAIT_LOG;
                    end
                end
                ST_REPORT:
                begin
                    if (!busy)
                    begin
                        hex_val <= err_q ? ERR_WORD : rdata_q;
                        trigger <= 1'b1;
                        pass_q  <= pass_q + 1'b1;
                        // the walk covers one address past the end, then wraps.
                        addr_q  <= (addr_q == ADDR_W'(MEM_DEPTH)) ? '0 : addr_q + 1'b1;
                        next_q  <= ST_STORE;
                        state   <= ST_WAIT_LOG;
                    end
                end
                ST_WAIT_MEM:
                begin
                    if (ready)
                    begin
                        enable  <= 1'b0;
                        rdata_q <= mem_rsp.rdata;    // the last one kept is the load's.
                        err_q   <= mem_rsp.bus_err;
                        state   <= next_q;
                    end
                end
                ST_WAIT_LOG:
                begin
                    trigger <= 1'b0;
                    // busy only rises the cycle after the trigger pulse.
                    if (!trigger && !busy)
                    begin
                        state <= next_q;
                    end
                end
                default:
                begin
                    state <= ST_BANNER;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $fell(enable) |-> $past(ready));
    assert property (@(posedge clk) disable iff (!rst_n) $rose(trigger) |-> !busy);

endmodule

// ==== verilog/mem_logger_top.sv ====
`timescale 1ns/10ps

module mem_logger_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [mem_logger_pkg::BAUD_W-1:0] baud_div,
    output logic                              tx
);
    import mem_logger_pkg::*;

    logic              enable;
    logic              ready;
    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    logic              trigger;
    logic              busy;
    logic [DATA_W-1:0] hex_val;

    mem_test_sequencer i_sequencer (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (enable),
        .mem_req (mem_req),
        .ready   (ready),
        .mem_rsp (mem_rsp),
        .trigger (trigger),
        .hex_val (hex_val),
        .busy    (busy)
    );

    sp_bram i_sp_bram (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .req    (mem_req),
        .ready  (ready),
        .rsp    (mem_rsp)
    );

    uart_hex_logger i_hex_logger (
        .clk      (clk),
        .rst_n    (rst_n),
        .trigger  (trigger),
        .hex_val  (hex_val),
        .baud_div (baud_div),
        .tx       (tx),
        .busy     (busy)
    );

endmodule

// ==== test/mem_logger_tb.sv ====
`timescale 1ns/10ps

module mem_logger_tb;
    import mem_logger_pkg::*;

    localparam int BAUD_DIV    = 4;
    localparam int START_LIMIT = 2000;    // cycles allowed while waiting for a start bit.
    localparam int NUM_PASSES  = 19;

    logic              clk;
    logic              rst_n;
    logic [BAUD_W-1:0] baud_div;
    logic              tx;

    int         error_count;
    int         line_count;
    int         rand_seed;
    bit         aborted;
    logic [7:0] line_chars [MSG_CHARS];
    logic       line_start [MSG_CHARS];
    logic       line_stop  [MSG_CHARS];
    seq_state_e dbg_state;

    mem_logger_top i_mem_logger_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .tx       (tx)
    );

    assign dbg_state = i_mem_logger_top.i_sequencer.state;    // shown when the line goes quiet.

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    task automatic compare_word(input string test_name, input logic [DATA_W-1:0] expected,
                                input logic [DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error %s: expected %08h, actual %08h", test_name, expected, actual);
        end
    endtask

    task automatic compare_char(input string test_name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error %s: expected %02h, actual %02h", test_name, expected, actual);
        end
    endtask

    task automatic compare_bit(input string test_name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error %s: expected %b, actual %b", test_name, expected, actual);
        end
    endtask

    function automatic bit is_upper_hex(input logic [7:0] c);
        return (c >= 8'h30 && c <= 8'h39) || (c >= 8'h41 && c <= 8'h46);
    endfunction

    function automatic logic [3:0] ascii_to_nibble(input logic [7:0] c);
        if (c <= 8'h39)
        begin
            return 4'(c - 8'h30);
        end
        return 4'(c - 8'h37);
    endfunction

    // the top byte comes from the lane write, the rest from the full store of n.
    function automatic logic [DATA_W-1:0] readback_value(input int n);
        return {8'hA5, 24'(n)};
    endfunction

    // tx changes on the rising edge, so every sample is taken on the falling one.
    task automatic receive_char(output logic [7:0] data, output logic start_bit,
                                output logic stop_bit);
        int waited;
        waited    = 0;
        data      = '0;
        start_bit = 1'b1;
        stop_bit  = 1'b0;
        @(negedge clk);
        while (tx !== 1'b0 && waited < START_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (tx !== 1'b0)
        begin
            error_count++;
            aborted = 1'b1;
            $display("timeout: no start bit within %0d cycles on line %0d, sequencer in %s",
                     START_LIMIT, line_count, dbg_state.name());
        end
        else
        begin
            repeat (BAUD_DIV / 2) @(negedge clk);
            start_bit = tx;
            for (int i = 0; i < 8; i++)
            begin
                repeat (BAUD_DIV) @(negedge clk);
                data[i] = tx;    // LSB first.
            end
            repeat (BAUD_DIV) @(negedge clk);
            stop_bit = tx;
        end
    endtask

    task automatic receive_line(output logic [DATA_W-1:0] word);
        word = '0;
        for (int c = 0; c < MSG_CHARS && !aborted; c++)
        begin
            receive_char(line_chars[c], line_start[c], line_stop[c]);
        end
        if (!aborted)
        begin
            test_frame_format();
            for (int c = 0; c < HEX_DIGITS; c++)
            begin
                word = {word[DATA_W-5:0], ascii_to_nibble(line_chars[c])};
            end
        end
        line_count++;
    endtask

    task automatic test_idle_reset();
        rst_n = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            compare_bit("test_idle_reset", 1'b1, tx);
        end
        @(posedge clk);
        #2 rst_n = 1'b1;
    endtask

    task automatic test_frame_format();
        for (int c = 0; c < MSG_CHARS; c++)
        begin
            compare_bit($sformatf("test_frame_format line %0d start", line_count), 1'b0,
                        line_start[c]);
            compare_bit($sformatf("test_frame_format line %0d stop", line_count), 1'b1,
                        line_stop[c]);
        end
        for (int c = 0; c < HEX_DIGITS; c++)
        begin
            if (!is_upper_hex(line_chars[c]))
            begin
                error_count++;
                $display("test_frame_format: line %0d character %0d is %02h, no uppercase hex digit",
                         line_count, c + 1, line_chars[c]);
            end
        end
        compare_char("test_frame_format CR", 8'h0D, line_chars[HEX_DIGITS]);
        compare_char("test_frame_format LF", 8'h0A, line_chars[HEX_DIGITS+1]);
    endtask

    task automatic test_banner();
        logic [DATA_W-1:0] word;
        receive_line(word);
        if (!aborted)
        begin
            compare_word("test_banner", BANNER_WORD, word);
        end
    endtask

    task automatic test_pass_markers(input int n, input logic [DATA_W-1:0] first,
                                     input logic [DATA_W-1:0] second);
        compare_word($sformatf("test_pass_markers pass %0d store", n), STORE_MARK, first);
        compare_word($sformatf("test_pass_markers pass %0d load", n), LOAD_MARK, second);
    endtask

    task automatic test_readback(input int n, input logic [DATA_W-1:0] report);
        if (n % (MEM_DEPTH + 1) < MEM_DEPTH)
        begin
            compare_word($sformatf("test_readback pass %0d", n), readback_value(n), report);
        end
    endtask

    // pass 16 is the address past the end, and pass 17 wraps back to word 0.
    task automatic test_bus_error(input int n, input logic [DATA_W-1:0] report);
        if (n == MEM_DEPTH)
        begin
            compare_word("test_bus_error pass 16", ERR_WORD, report);
        end
        else if (n == MEM_DEPTH + 1)
        begin
            compare_word("test_bus_error pass 17", readback_value(n), report);
        end
    endtask

    task automatic run_passes();
        logic [DATA_W-1:0] store_word;
        logic [DATA_W-1:0] load_word;
        logic [DATA_W-1:0] report_word;
        for (int n = 0; n < NUM_PASSES && !aborted; n++)
        begin
            receive_line(store_word);
            receive_line(load_word);
            receive_line(report_word);
            if (!aborted)
            begin
                test_pass_markers(n, store_word, load_word);
                test_readback(n, report_word);
                test_bus_error(n, report_word);
            end
        end
    endtask

    initial
    begin
        rst_n       = 1'b0;
        baud_div    = BAUD_W'(BAUD_DIV);
        error_count = 0;
        line_count  = 0;
        aborted     = 1'b0;
        rand_seed   = $urandom(88);
        test_idle_reset();
        test_banner();
        run_passes();
        $display("errors: %0d, lines received: %0d", error_count, line_count);
        if (error_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== mem_logger.f ====
common/mem_logger_pkg.sv
memory/sp_bram.sv
uart/baud_timer.sv
uart/uart_hex_logger.sv
verilog/mem_test_sequencer.sv
verilog/mem_logger_top.sv
test/mem_logger_tb.sv

// ==== Bender.yml ====
package:
  name: mem_logger

sources:
  # shared package first, then the blocks, then the top level.
  - common/mem_logger_pkg.sv
  - memory/sp_bram.sv
  - uart/baud_timer.sv
  - uart/uart_hex_logger.sv
  - verilog/mem_test_sequencer.sv
  - verilog/mem_logger_top.sv

  - target: test
    files:
      - test/mem_logger_tb.sv
